// File: dv/mpls_ingress_checker.sv
// mpls ingress checker
// bound assertions on the converged output and the overflow flags
`timescale 1ns/1ps

module mpls_ingress_checker (
    input logic                         clk_ifc,
    input logic                         reset,
    input logic                         out_valid,
    input ingress_pkg::converged_word_t out_word,
    input ingress_pkg::port_mask_t      overflow
);
    import ingress_pkg::*;

    // set between the first and the last word of a packet
    logic        in_packet;
    port_index_t port_q;

    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            in_packet <= 1'b0;
        end else if (out_valid) begin
            in_packet <= !out_word.last;
        end
    end

    // tag of the previous word sent
    always_ff @(posedge clk_ifc) begin
        if (out_valid) begin
            port_q <= out_word.port;
        end
    end

    no_valid_in_reset: assert property (@(posedge clk_ifc) $past(reset) |-> !out_valid)
        else $error("out_valid high during reset");

    // 2^k - 1 pattern, k at least one
    keep_contiguous: assert property (@(posedge clk_ifc) disable iff (reset)
        out_valid |-> (out_word.keep != '0)
                      && ((out_word.keep & (out_word.keep + 8'd1)) == '0))
        else $error("keep empty or not contiguous from lane 0");

    keep_full_mid: assert property (@(posedge clk_ifc) disable iff (reset)
        out_valid && !out_word.last |-> out_word.keep == '1)
        else $error("partial keep on a word without last");

    port_stable: assert property (@(posedge clk_ifc) disable iff (reset)
        out_valid && in_packet |-> out_word.port == port_q)
        else $error("port tag changed inside a packet");

    // sticky flags
    overflow_sticky: assert property (@(posedge clk_ifc) disable iff (reset)
        ($past(overflow) & ~overflow) == '0)
        else $error("overflow bit fell without reset");

endmodule

bind mpls_ingress mpls_ingress_checker mpls_ingress_checker_inst (
    .clk_ifc   (clk_ifc),
    .reset     (reset),
    .out_valid (out_valid),
    .out_word  (out_word),
    .overflow  (overflow)
);

// File: dv/mpls_ingress_tb.sv
// mpls ingress testbench
// random packets on both ports against a credit limited sink
`timescale 1ns/1ps

module mpls_ingress_tb;
    import ingress_pkg::*;

    logic            clk_ifc      = 1'b0;
    logic            reset        = 1'b1;
    logic            narrow_valid = 1'b0;
    logic [7:0]      narrow_data  = '0;
    logic            narrow_last  = 1'b0;
    logic            wide_valid   = 1'b0;
    logic [31:0]     wide_data    = '0;
    logic            wide_last    = 1'b0;
    logic            out_credit   = 1'b0;
    logic            out_valid;
    converged_word_t out_word;
    port_mask_t      overflow;

    int              seed        = 32'hd56e;
    int              credit_seed = 32'hd56e;
    int              granted     = 0;
    int              received    = 0;
    int              owed        = 0;
    int              sent_pkts[NUM_PORTS] = '{default: 0};
    int              rcvd_pkts[NUM_PORTS] = '{default: 0};
    // sink stops returning credits while set
    logic            hold_credit = 1'b0;
    // expected converged words per port
    ingress_word_t   exp_q0[$];
    ingress_word_t   exp_q1[$];
    // bytes and per packet word counts queued for the drivers
    logic [7:0]      nar_bytes[$];
    logic [7:0]      wide_bytes[$];
    int              nar_lens[$];
    int              wide_lens[$];

    always #2 clk_ifc = ~clk_ifc;

    mpls_ingress mpls_ingress_inst (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, want);
            abort_run("output did not match the reference");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference and stimulus

    // byte i lands in lane i%8 of word i/8 and sets its keep bit
    function automatic void build_expected(input int port, input logic [7:0] pkt[$]);
        ingress_word_t w;
        int            lane;
        w = '0;
        for (int i = 0; i < pkt.size(); i++) begin
            lane = i % CONV_BYTES;
            w.data[lane*8 +: 8] = pkt[i];
            w.keep[lane]        = 1'b1;
            w.last              = (i == pkt.size() - 1);
            if (lane == CONV_BYTES - 1 || w.last) begin
                if (port == 0) begin
                    exp_q0.push_back(w);
                end else begin
                    exp_q1.push_back(w);
                end
                w = '0;
            end
        end
    endfunction

    // len 0 picks 8 to 128 bytes in whole port words
    task automatic make_packet(input int port, input int len);
        logic [7:0] pkt[$];
        logic [7:0] b;
        int         width;
        int         n;
        width = (port == 0) ? 1 : 4;
        n     = len;
        if (n == 0) begin
            n = 8 + width * int'({$random(seed)} % (120 / width + 1));
        end
        for (int i = 0; i < n; i++) begin
            b = 8'($random(seed));
            pkt.push_back(b);
            if (port == 0) begin
                nar_bytes.push_back(b);
            end else begin
                wide_bytes.push_back(b);
            end
        end
        if (port == 0) begin
            nar_lens.push_back(n);
        end else begin
            wide_lens.push_back(n / 4);
        end
        build_expected(port, pkt);
        sent_pkts[port]++;
    endtask

    task automatic drive_narrow();
        int words;
        while (nar_lens.size() != 0) begin
            words = nar_lens.pop_front();
            for (int i = 0; i < words; i++) begin
                @(negedge clk_ifc);
                narrow_valid = 1'b1;
                narrow_data  = nar_bytes.pop_front();
                narrow_last  = (i == words - 1);
            end
        end
        @(negedge clk_ifc);
        narrow_valid = 1'b0;
        narrow_last  = 1'b0;
    endtask

    // first byte of a port word in bits 7:0
    task automatic drive_wide();
        int words;
        while (wide_lens.size() != 0) begin
            words = wide_lens.pop_front();
            for (int i = 0; i < words; i++) begin
                @(negedge clk_ifc);
                wide_valid = 1'b1;
                for (int k = 0; k < 4; k++) begin
                    wide_data[8*k +: 8] = wide_bytes.pop_front();
                end
                wide_last = (i == words - 1);
            end
        end
        @(negedge clk_ifc);
        wide_valid = 1'b0;
        wide_last  = 1'b0;
    endtask

    task automatic wait_drained(input int limit);
        int cycles;
        cycles = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && cycles < limit) begin
            @(posedge clk_ifc);
            cycles++;
        end
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            abort_run("timeout waiting for the expected words on the output");
        end
    endtask

    task automatic wait_credits_spent(input int limit);
        int cycles;
        cycles = 0;
        while (received != granted && cycles < limit) begin
            @(posedge clk_ifc);
            cycles++;
        end
        if (received != granted) begin
            abort_run("timeout waiting for the DUT to spend its credits");
        end
    endtask

    task automatic send_alone(input int port, input int len);
        make_packet(port, len);
        if (port == 0) begin
            drive_narrow();
        end else begin
            drive_wide();
        end
        wait_drained(1000);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sink side

    // CREDIT_MAX after reset and then one back per word
    always @(negedge clk_ifc) begin
        if (reset) begin
            owed       = CREDIT_MAX;
            out_credit = 1'b0;
        end else begin
            if (out_valid) begin
                owed++;
            end
            out_credit = 1'b0;
            // now and then a gap before the return
            if (!hold_credit && owed > 0 && ($random(credit_seed) & 7) != 0) begin
                out_credit = 1'b1;
                owed--;
                granted++;
            end
        end
    end

    // queue picked by the port tag
    always @(negedge clk_ifc) begin
        ingress_word_t want;
        logic          found;
        if (!reset && out_valid) begin
            received++;
            found = 1'b1;
            want  = '0;
            if (out_word.port == port_index_t'(0) && exp_q0.size() != 0) begin
                want = exp_q0.pop_front();
            end else if (out_word.port == port_index_t'(1) && exp_q1.size() != 0) begin
                want = exp_q1.pop_front();
            end else begin
                found = 1'b0;
            end
            if (received > granted) begin
                abort_run("a word came out beyond the credits granted");
            end else if (!found) begin
                abort_run($sformatf("word on port %0d with nothing expected", out_word.port));
            end else begin
                check_value("out_word.data", 64'(out_word.data), 64'(want.data));
                check_value("out_word.keep", 64'(out_word.keep), 64'(want.keep));
                check_value("out_word.last", 64'(out_word.last), 64'(want.last));
                if (want.last) begin
                    rcvd_pkts[out_word.port]++;
                end
            end
        end
    end

    initial begin
        repeat (4) @(posedge clk_ifc);
        @(negedge clk_ifc);
        reset = 1'b0;

        // narrow port alone
        repeat (4) send_alone(0, 0);
        // wide port alone where 12 and 20 bytes end half full
        send_alone(1, 12);
        send_alone(1, 20);
        repeat (3) send_alone(1, 0);

        // both ports at once
        repeat (3) begin
            make_packet(0, 0);
            make_packet(1, 0);
        end
        fork
            drive_narrow();
            drive_wide();
        join
        wait_drained(3000);

        // credits withheld while 8 words per port fit the buffers
        @(posedge clk_ifc);
        hold_credit = 1'b1;
        make_packet(0, 64);
        make_packet(1, 64);
        fork
            drive_narrow();
            drive_wide();
        join
        wait_credits_spent(1000);
        repeat (20) @(posedge clk_ifc);
        @(posedge clk_ifc);
        hold_credit = 1'b0;
        wait_drained(1000);
        check_value("packets on port 0", 64'(rcvd_pkts[0]), 64'(sent_pkts[0]));
        check_value("packets on port 1", 64'(rcvd_pkts[1]), 64'(sent_pkts[1]));
        check_value("overflow", 64'(overflow), 64'(0));

        // 512 narrow bytes with no credit coming back
        @(posedge clk_ifc);
        hold_credit = 1'b1;
        repeat (4) make_packet(0, 128);
        drive_narrow();
        repeat (4) @(posedge clk_ifc);
        check_value("overflow", 64'(overflow), 64'(2'b01));
        repeat (40) @(posedge clk_ifc);
        check_value("overflow", 64'(overflow), 64'(2'b01));

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: logic/ingress_pkg.sv
// mpls ingress front end shared definitions
// widths, buffer depths and bus word layouts

package ingress_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes

    // bytes per converged word toward the packet processor
    localparam int CONV_BYTES  = 8;
    localparam int NUM_PORTS   = 2;
    // converged words per port buffer, 256 byte packets at most
    localparam int FIFO_DEPTH  = 32;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);
    // credits granted by the sink after reset
    localparam int CREDIT_MAX  = 8;

    ////////////////////////////////////////////////////////////////////////////
    // vector types

    typedef logic [CONV_BYTES*8-1:0]        conv_data_t;
    // bit n covers byte lane n
    typedef logic [CONV_BYTES-1:0]          conv_keep_t;
    typedef logic [$clog2(NUM_PORTS)-1:0]   port_index_t;
    typedef logic [NUM_PORTS-1:0]           port_mask_t;
    typedef logic [$clog2(CREDIT_MAX+1)-1:0] credit_count_t;
    typedef logic [FIFO_ADDR_W-1:0]         fifo_addr_t;
    // one extra bit so a full buffer is representable
    typedef logic [FIFO_ADDR_W:0]           fifo_count_t;

    ////////////////////////////////////////////////////////////////////////////
    // bus words

    // packer output, one converged word
    typedef struct packed {
        conv_data_t data;
        conv_keep_t keep;
        logic       last;
    } ingress_word_t;

    // converged bus word, source port in the user field
    typedef struct packed {
        conv_data_t  data;
        conv_keep_t  keep;
        logic        last;
        port_index_t port;
    } converged_word_t;

    // packet arbiter states
    typedef enum logic {
        arb_idle,
        arb_stream
    } arb_state_t;

endpackage

// File: logic/ingress_word_packer.sv
// ingress word packer
// gathers port words into converged words and buffers whole packets
`timescale 1ns/1ps

module ingress_word_packer #(
    parameter int PORT_BYTES = 1
) (
    input  logic                       clk_ifc,
    input  logic                       reset,
    input  logic                       in_valid,
    input  logic [PORT_BYTES*8-1:0]    in_data,
    input  logic                       in_last,
    input  logic                       pop,
    output ingress_pkg::ingress_word_t head_word,
    output logic                       pkt_ready,
    output logic                       overflow
);
    import ingress_pkg::*;

    // port words per converged word
    localparam int LANES  = CONV_BYTES / PORT_BYTES;
    localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic [LANE_W-1:0] lane;
    logic              lane_full;
    ingress_word_t     asm_word;
    ingress_word_t     asm_next;
    logic              wr_pending;
    logic              wr_en;
    logic              full;

    ingress_word_t     mem [FIFO_DEPTH];
    fifo_addr_t        wr_ptr;
    fifo_addr_t        rd_ptr;
    fifo_count_t       fill;
    fifo_count_t       pkt_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // assembly

    assign lane_full = (int'(lane) == LANES - 1);

    // little endian, first port word in lane 0
    always_comb begin
        asm_next = asm_word;
        // new converged word, clear stale bytes above the valid ones
        if (lane == '0) begin
            asm_next.data = '0;
            asm_next.keep = '0;
        end
        asm_next.data[int'(lane)*PORT_BYTES*8 +: PORT_BYTES*8] = in_data;
        asm_next.keep[int'(lane)*PORT_BYTES +: PORT_BYTES]     = '1;
        asm_next.last = in_last;
    end

    always_ff @(posedge clk_ifc) begin
        if (in_valid) begin
            asm_word <= asm_next;
        end
    end

    // lane counter, write request one clock after the filling word
    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            lane       <= '0;
            wr_pending <= 1'b0;
        end else begin
            wr_pending <= in_valid && (lane_full || in_last);
            if (in_valid) begin
                lane <= (lane_full || in_last) ? '0 : lane + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // store and forward buffer

    assign full  = (fill == fifo_count_t'(FIFO_DEPTH));
    // word at a full buffer is dropped
    assign wr_en = wr_pending && !full;

    always_ff @(posedge clk_ifc) begin
        if (wr_en) begin
            mem[wr_ptr] <= asm_word;
        end
    end

    // show-ahead head
    assign head_word = mem[rd_ptr];

    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // complete packets held in the buffer
    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            pkt_cnt <= '0;
        end else begin
            case ({wr_en && asm_word.last, pop && head_word.last})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
        end
    end

    assign pkt_ready = (pkt_cnt != '0);

    // sticky until reset
    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (wr_pending && full) begin
            overflow <= 1'b1;
        end
    end

endmodule

// File: logic/mpls_ingress.sv
// mpls ingress front end
// narrow and wide ports packed side by side, merged onto the converged bus
`timescale 1ns/1ps

module mpls_ingress (
    input  logic                         clk_ifc,
    input  logic                         reset,
    input  logic                         narrow_valid,
    input  logic [7:0]                   narrow_data,
    input  logic                         narrow_last,
    input  logic                         wide_valid,
    input  logic [31:0]                  wide_data,
    input  logic                         wide_last,
    output logic                         out_valid,
    output ingress_pkg::converged_word_t out_word,
    input  logic                         out_credit,
    output ingress_pkg::port_mask_t      overflow
);
    import ingress_pkg::*;

    // index 0 narrow, index 1 wide
    port_mask_t    pkt_ready;
    port_mask_t    pop;
    ingress_word_t head_word0;
    ingress_word_t head_word1;

    // port 0, one byte per word
    ingress_word_packer #(
        .PORT_BYTES (1)
    ) narrow_packer (
        .clk_ifc   (clk_ifc),
        .reset     (reset),
        .in_valid  (narrow_valid),
        .in_data   (narrow_data),
        .in_last   (narrow_last),
        .pop       (pop[0]),
        .head_word (head_word0),
        .pkt_ready (pkt_ready[0]),
        .overflow  (overflow[0])
    );

    // port 1, four bytes per word
    ingress_word_packer #(
        .PORT_BYTES (4)
    ) wide_packer (
        .clk_ifc   (clk_ifc),
        .reset     (reset),
        .in_valid  (wide_valid),
        .in_data   (wide_data),
        .in_last   (wide_last),
        .pop       (pop[1]),
        .head_word (head_word1),
        .pkt_ready (pkt_ready[1]),
        .overflow  (overflow[1])
    );

    packet_arbiter packet_arbiter_inst (
        .clk_ifc    (clk_ifc),
        .reset      (reset),
        .pkt_ready  (pkt_ready),
        .head_word0 (head_word0),
        .head_word1 (head_word1),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .out_credit (out_credit)
    );

endmodule

// File: logic/packet_arbiter.sv
// packet arbiter
// round-robin over whole packets, port tagging, credit counted output
`timescale 1ns/1ps

module packet_arbiter (
    input  logic                         clk_ifc,
    input  logic                         reset,
    input  ingress_pkg::port_mask_t      pkt_ready,
    input  ingress_pkg::ingress_word_t   head_word0,
    input  ingress_pkg::ingress_word_t   head_word1,
    output ingress_pkg::port_mask_t      pop,
    output logic                         out_valid,
    output ingress_pkg::converged_word_t out_word,
    input  logic                         out_credit
);
    import ingress_pkg::*;

    arb_state_t    state;
    port_index_t   grant;
    port_index_t   last_served;
    port_index_t   pick;
    credit_count_t credits;
    ingress_word_t head_sel;
    logic          send;

    ////////////////////////////////////////////////////////////////////////////
    // selection

    // other port first, else the one just served
    always_comb begin
        pick = ~last_served;
        if (!pkt_ready[pick]) begin
            pick = last_served;
        end
    end

    assign head_sel = (grant == port_index_t'(1)) ? head_word1 : head_word0;

    // one word per clock while a credit is held
    assign send = (state == arb_stream) && (credits != '0);

    always_comb begin
        pop        = '0;
        pop[grant] = send;
    end

    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            state       <= arb_idle;
            grant       <= '0;
            // port 0 wins the first tie
            last_served <= '1;
        end else begin
            case (state)
                arb_idle: begin
                    if (pkt_ready != '0) begin
                        grant <= pick;
                        state <= arb_stream;
                    end
                end
                arb_stream: begin
                    // packet done once its last word leaves the buffer
                    if (send && head_sel.last) begin
                        last_served <= grant;
                        state       <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register

    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (send) begin
            out_word.data <= head_sel.data;
            out_word.keep <= head_sel.keep;
            out_word.last <= head_sel.last;
            out_word.port <= grant;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // credits

    // +1 per returned credit, -1 per word sent
    always_ff @(posedge clk_ifc) begin
        if (reset) begin
            credits <= '0;
        end else if (out_credit && !send) begin
            if (credits < credit_count_t'(CREDIT_MAX)) begin
                credits <= credits + 1'b1;
            end
        end else if (send && !out_credit) begin
            credits <= credits - 1'b1;
        end
    end

endmodule

// File: project.f
logic/ingress_pkg.sv
logic/ingress_word_packer.sv
logic/packet_arbiter.sv
logic/mpls_ingress.sv
dv/mpls_ingress_checker.sv
dv/mpls_ingress_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the mpls ingress testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module mpls_ingress_tb -f project.f -o mpls_ingress_sim
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

./obj_dir/mpls_ingress_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Simulation FAILED" "$log"; then
    echo "run_sim: failure reported, see $log"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "run_sim: simulator exited with status $status"
    exit 1
fi
if ! grep -q "Simulation PASSED" "$log"; then
    echo "run_sim: no pass line found in $log"
    exit 1
fi
echo "run_sim: done"
exit 0
